//--- src/tsi_defines.svh
`ifndef TSI_DEFINES_SVH
`define TSI_DEFINES_SVH

`default_nettype none

// frame geometry of the switch
`define TSI_NUM_STREAMS 8       // serial TDM inputs and outputs
`define TSI_CHANS_PER_STREAM 4  // 8-bit channels carried per stream in one frame
`define TSI_NUM_SLOTS 32        // streams times channels, one slot per channel
`define TSI_SLOT_BITS 8         // a slot is one byte, sent lsb first

// connection memory word layout
`define TSI_CONN_BITS 16  // width of one connection word

// flag positions inside a connection word
// the low byte holds either the fixed pattern or the source slot
`define TSI_CONST_BIT 15   // set means the slot plays the low byte as a pattern
`define TSI_ENABLE_BIT 13  // clear means the slot outputs zero

`default_nettype wire

`endif

//--- src/tsi_frame_pkg.sv
`include "tsi_defines.svh"

`default_nettype none

// types that describe where the switch is inside a TDM frame
package tsi_frame_pkg;

	// slot number over the whole frame, stream k owns slots 4k to 4k+3
	typedef logic [$clog2(`TSI_NUM_SLOTS)-1:0] slot_t;

	// channel inside one stream, also the byte number in the frame
	typedef logic [$clog2(`TSI_CHANS_PER_STREAM)-1:0] chan_t;

	typedef logic [$clog2(`TSI_SLOT_BITS)-1:0] bit_idx_t; // bit of the current byte

	// current bit time, channel in the upper bits so that the whole struct
	// counts straight from 0 to 31 across the frame
	typedef struct packed {
		chan_t chan;        // which byte of the stream is on the line
		bit_idx_t bit_idx;  // which bit of that byte, lsb goes first
	} frame_pos_t;

	// one bit per serial stream, bit k belongs to stream k
	typedef logic [`TSI_NUM_STREAMS-1:0] stream_bits_t;

endpackage

`default_nettype wire

//--- src/tsi_conn_pkg.sv
`include "tsi_defines.svh"

`default_nettype none

// types of the connection memory and of its control port
package tsi_conn_pkg;

	// one word per output slot, msb first
	// spare fields fill the gaps between the flags and are ignored by the switch
	typedef struct packed {
		logic const_mode;                                            // play payload as a pattern
		logic [`TSI_CONST_BIT-`TSI_ENABLE_BIT-2:0] spare_hi;         // unused
		logic enable;                                                // slot is driven at all
		logic [`TSI_CONN_BITS-`TSI_SLOT_BITS-4:0] spare_mid;         // unused
		logic [`TSI_SLOT_BITS-1:0] payload;                          // pattern or source slot
	} conn_word_t;

	// control write request, a single cycle strobe with address and data
	// the write lands at the clock edge of the same cycle
	typedef struct packed {
		logic write;                 // strobe, high for one cycle per write
		tsi_frame_pkg::slot_t addr;  // output slot whose word is replaced
		conn_word_t data;            // new connection word
	} conn_write_t;

endpackage

`default_nettype wire

//--- src/tsi_frame_counter.sv
`include "tsi_defines.svh"

`default_nettype none

// frame position counter
// every cycle with input_valid high is one bit time, and only those cycles
// move the position on, so a gap in input_valid freezes the whole switch
module tsi_frame_counter (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      input_valid,
	output tsi_frame_pkg::frame_pos_t pos,
	output logic                      frame_end,
	output logic                      played
);

	// the position runs as one flat count, channel bits on top of the bit index
	logic [$bits(tsi_frame_pkg::frame_pos_t)-1:0] count;

	assign pos = tsi_frame_pkg::frame_pos_t'(count); // channel and bit view of the count

	// last bit time of the frame, only during an actual bit time
	assign frame_end = input_valid && (count == '1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count  <= '0;   // start on bit 0 of channel 0
			played <= 1'b0; // nothing captured yet
		end
		else
		begin
			if (input_valid)
				count <= count + 1'b1; // wraps from 31 back to 0 at frame end

			// once the first frame is in the speech memory it stays there,
			// so the flag never falls again until reset
			if (frame_end)
				played <= 1'b1;
		end
	end

	// the frame length has to match the slot count for the wrap to line up
	// with the slot numbering used by the memories
	// this holds for the geometry in the defines header:
	// 4 channels of 8 bits give the 32 bit times of a frame,
	// so the count width equals the slot number width

endmodule

`default_nettype wire

//--- src/tsi_conn_memory.sv
`include "tsi_defines.svh"

`default_nettype none

// connection memory, one word per output slot
// written by the control port, read for all eight streams at once
module tsi_conn_memory (
	input  logic                                           clk,
	input  logic                                           reset,
	input  tsi_conn_pkg::conn_write_t                      control,
	input  tsi_frame_pkg::frame_pos_t                      pos,
	output tsi_conn_pkg::conn_word_t [`TSI_NUM_STREAMS-1:0] conn_words
);

	tsi_conn_pkg::conn_word_t words [`TSI_NUM_SLOTS]; // indexed by output slot

	// all words start disabled so that the outputs stay quiet until configured
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `TSI_NUM_SLOTS; i++)
				words[i] <= '0;
		end
		else if (control.write)
		begin
			words[control.addr] <= control.data; // a bit time in this cycle still sees the old word
		end
	end

	// the output slot of stream k in the current channel is 4k + chan
	always_comb
	begin
		for (int k = 0; k < `TSI_NUM_STREAMS; k++)
		begin
			conn_words[k] = words[tsi_frame_pkg::slot_t'(k * `TSI_CHANS_PER_STREAM)
				+ tsi_frame_pkg::slot_t'(pos.chan)];
		end
	end

endmodule

`default_nettype wire

//--- src/tsi_speech_memory.sv
`include "tsi_defines.svh"

`default_nettype none

// ping-pong speech memory
// one bank fills with the frame on the inputs while the other bank,
// holding the previous frame, is read by the output side
// at the end of each frame the two banks swap roles
module tsi_speech_memory (
	input  logic                                           clk,
	input  logic                                           reset,
	input  logic                                           input_valid,
	input  logic                                           frame_end,
	input  tsi_frame_pkg::frame_pos_t                      pos,
	input  tsi_frame_pkg::stream_bits_t                    stream_in,
	input  tsi_conn_pkg::conn_word_t [`TSI_NUM_STREAMS-1:0] conn_words,
	output tsi_frame_pkg::stream_bits_t                    src_bits
);

	// two banks of 32 bytes, addressed by bank then slot then bit
	logic [`TSI_SLOT_BITS-1:0] bank_mem [2][`TSI_NUM_SLOTS];

	logic capture_bank; // bank being filled this frame, the other one plays out

	tsi_frame_pkg::slot_t capture_slot [`TSI_NUM_STREAMS]; // where each input bit lands
	tsi_frame_pkg::slot_t source_slot [`TSI_NUM_STREAMS];  // where each output bit comes from

	// capture address of stream k is 4k + chan, the same slot numbering
	// the connection memory uses for its output slots
	always_comb
	begin
		for (int k = 0; k < `TSI_NUM_STREAMS; k++)
		begin
			capture_slot[k] = tsi_frame_pkg::slot_t'(k * `TSI_CHANS_PER_STREAM)
				+ tsi_frame_pkg::slot_t'(pos.chan);
		end
	end

	// the source slot sits in the low bits of the payload byte
	// in constant mode this is garbage, but the output side ignores it then
	always_comb
	begin
		for (int k = 0; k < `TSI_NUM_STREAMS; k++)
		begin
			source_slot[k] = conn_words[k].payload[$bits(tsi_frame_pkg::slot_t)-1:0];
		end
	end

	// bank select, the only control state in here
	always_ff @(posedge clk)
	begin
		if (reset)
			capture_bank <= 1'b0;
		else if (frame_end)
			capture_bank <= ~capture_bank; // the frame just finished becomes the playback frame
	end

	// bit writes into the capture bank, one bit per stream per bit time
	// no reset, the played flag keeps stale bytes off the outputs
	always_ff @(posedge clk)
	begin
		if (input_valid)
		begin
			for (int k = 0; k < `TSI_NUM_STREAMS; k++)
				bank_mem[capture_bank][capture_slot[k]][pos.bit_idx] <= stream_in[k];
		end
	end

	// combinational read from the playback bank
	// the bit index follows the output position, so slot bytes go out lsb first
	always_comb
	begin
		for (int k = 0; k < `TSI_NUM_STREAMS; k++)
			src_bits[k] = bank_mem[~capture_bank][source_slot[k]][pos.bit_idx];
	end

endmodule

`default_nettype wire

//--- src/tsi_output_select.sv
`include "tsi_defines.svh"

`default_nettype none

// output stage, chooses per stream between silence, the fixed pattern and
// the switched source bit, then registers the result and the frame sync
module tsi_output_select (
	input  logic                                           clk,
	input  logic                                           reset,
	input  logic                                           input_valid,
	input  logic                                           played,
	input  tsi_frame_pkg::frame_pos_t                      pos,
	input  tsi_conn_pkg::conn_word_t [`TSI_NUM_STREAMS-1:0] conn_words,
	input  tsi_frame_pkg::stream_bits_t                    src_bits,
	output tsi_frame_pkg::stream_bits_t                    stream_out,
	output logic                                           sync
);

	tsi_frame_pkg::stream_bits_t next_bits; // selected bit per stream for this bit time

	// selection per stream
	// before the first frame is complete there is nothing valid to play,
	// so every stream sends zero during that frame
	always_comb
	begin
		for (int k = 0; k < `TSI_NUM_STREAMS; k++)
		begin
			if (!played || !conn_words[k].enable)
				next_bits[k] = 1'b0;                                  // slot switched off
			else if (conn_words[k].const_mode)
				next_bits[k] = conn_words[k].payload[pos.bit_idx];   // pattern, lsb first
			else
				next_bits[k] = src_bits[k];                           // byte of the previous frame
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stream_out <= '0;
			sync       <= 1'b0;
		end
		else
		begin
			// outputs only move on bit times and hold through gaps
			if (input_valid)
				stream_out <= next_bits;

			// one cycle pulse with the first bit of every played frame
			sync <= input_valid && played && (pos == '0);
		end
	end

endmodule

`default_nettype wire

//--- src/tsi_switch.sv
`include "tsi_defines.svh"

`default_nettype none

// time slot interchange switch for eight serial TDM streams
// each frame is captured into the speech memory and played out, reordered
// by the connection memory, during the following frame
module tsi_switch (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        input_valid,
	input  tsi_conn_pkg::conn_write_t   control,
	input  tsi_frame_pkg::stream_bits_t stream_in,
	output tsi_frame_pkg::stream_bits_t stream_out,
	output logic                        sync
);

	tsi_frame_pkg::frame_pos_t pos; // current bit time inside the frame
	logic frame_end;                // last bit time of the frame
	logic played;                   // a complete frame sits in the speech memory

	// connection word of every stream's current output slot
	tsi_conn_pkg::conn_word_t [`TSI_NUM_STREAMS-1:0] conn_words;

	tsi_frame_pkg::stream_bits_t src_bits; // switched bits read from the playback bank

	// frame timing shared by everything else
	tsi_frame_counter u_tsi_frame_counter (
		.clk         (clk),
		.reset       (reset),
		.input_valid (input_valid),
		.pos         (pos),
		.frame_end   (frame_end),
		.played      (played)
	);

	// control port writes, per-stream reads at the current channel
	tsi_conn_memory u_tsi_conn_memory (
		.clk        (clk),
		.reset      (reset),
		.control    (control),
		.pos        (pos),
		.conn_words (conn_words)
	);

	// capture of the incoming frame and read of the previous one
	tsi_speech_memory u_tsi_speech_memory (
		.clk         (clk),
		.reset       (reset),
		.input_valid (input_valid),
		.frame_end   (frame_end),
		.pos         (pos),
		.stream_in   (stream_in),
		.conn_words  (conn_words),
		.src_bits    (src_bits)
	);

	// registered outputs, one cycle behind the bit time that made them
	tsi_output_select u_tsi_output_select (
		.clk         (clk),
		.reset       (reset),
		.input_valid (input_valid),
		.played      (played),
		.pos         (pos),
		.conn_words  (conn_words),
		.src_bits    (src_bits),
		.stream_out  (stream_out),
		.sync        (sync)
	);

endmodule

`default_nettype wire

//--- testbench/tsi_switch_props.sv
`default_nettype none

// port level properties of the switch that bind attaches to every tsi_switch
module tsi_switch_props (
	input logic                        clk,
	input logic                        reset,
	input logic                        input_valid,
	input tsi_frame_pkg::stream_bits_t stream_out,
	input logic                        sync
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0; // failed assertions so far

	// the pulse marks a single bit time because position 0 never repeats back to back
	sync_one_cycle: assert property (@(posedge clk) disable iff (reset) sync |=> !sync)
	else
	begin
		failures++;
		$error("sync stayed high for two cycles");
	end

	sync_after_valid: assert property (@(posedge clk) disable iff (reset)
		sync |-> $past(input_valid))
	else
	begin
		failures++;
		$error("sync rose without a bit time in the cycle before");
	end

	// a gap in input_valid freezes the outputs
	hold_in_gap: assert property (@(posedge clk) disable iff (reset)
		!input_valid |=> $stable(stream_out))
	else
	begin
		failures++;
		$error("stream_out changed after a cycle without input_valid");
	end

endmodule

bind tsi_switch tsi_switch_props u_tsi_switch_props (
	.clk         (clk),
	.reset       (reset),
	.input_valid (input_valid),
	.stream_out  (stream_out),
	.sync        (sync)
);

`default_nettype wire

//--- testbench/tsi_switch_tb.sv
`include "tsi_defines.svh"

`default_nettype none

// testbench for the time slot interchange switch
// random streams, random valid gaps and random control writes go into the DUT,
// and a frame level model predicts stream_out and sync for every cycle
module tsi_switch_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 8;
	localparam int RUN_BIT_TIMES = 40 * `TSI_NUM_SLOTS; // forty frames of 32 bit times

	// about 1,710 cycles are expected at the three quarter valid rate
	// and the limit leaves plenty of room above that
	localparam int MAX_CYCLES = 3000;

	logic clk;
	logic reset;
	logic input_valid;
	tsi_conn_pkg::conn_write_t control;
	tsi_frame_pkg::stream_bits_t stream_in;
	tsi_frame_pkg::stream_bits_t stream_out;
	logic sync;

	integer seed; // state of $random that starts from a fixed value

	// model of the frame as the outside world sees it
	logic [`TSI_SLOT_BITS-1:0] cur_frame [`TSI_NUM_SLOTS];  // bytes of the frame coming in
	logic [`TSI_SLOT_BITS-1:0] prev_frame [`TSI_NUM_SLOTS]; // last complete frame that plays now
	tsi_conn_pkg::conn_word_t conn_model [`TSI_NUM_SLOTS];  // one word per output slot
	int pos_model;                                          // bit time in the frame from 0 to 31
	logic played_model;                                     // a whole frame has been captured

	tsi_frame_pkg::stream_bits_t exp_stream; // stream_out expected after the last edge
	logic exp_sync;

	int bit_times;   // bit times applied since reset
	int cycle_count; // clock edges since start that the timeout counts
	int checks;

	tsi_switch u_tsi_switch (
		.clk         (clk),
		.reset       (reset),
		.input_valid (input_valid),
		.control     (control),
		.stream_in   (stream_in),
		.stream_out  (stream_out),
		.sync        (sync)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// state after reset with every connection word disabled and nothing captured
	task automatic model_reset();
		int i;
		for (i = 0; i < `TSI_NUM_SLOTS; i++)
			conn_model[i] = '0;
		pos_model = 0;
		played_model = 1'b0;
		exp_stream = '0;
		exp_sync = 1'b0;
	endtask

	// one clock edge seen by the model with the inputs the DUT samples there
	task automatic apply_edge();
		int k;
		int i;
		int chan;
		int bidx;
		tsi_conn_pkg::conn_word_t w;
		tsi_frame_pkg::slot_t src;
		chan = pos_model / `TSI_SLOT_BITS;
		bidx = pos_model % `TSI_SLOT_BITS;
		exp_sync = input_valid && played_model && (pos_model == 0); // first bit of a played frame
		if (input_valid)
		begin
			// output slot 4k+chan of the frame being played and bit bidx of its byte
			for (k = 0; k < `TSI_NUM_STREAMS; k++)
			begin
				w = conn_model[k * `TSI_CHANS_PER_STREAM + chan]; // word before any write in this cycle
				src = w.payload[$bits(tsi_frame_pkg::slot_t)-1:0];
				if (!played_model || !w.enable)
					exp_stream[k] = 1'b0;
				else if (w.const_mode)
					exp_stream[k] = w.payload[bidx]; // fixed pattern sent lsb first
				else
					exp_stream[k] = prev_frame[src][bidx];
			end
			for (k = 0; k < `TSI_NUM_STREAMS; k++)
				cur_frame[k * `TSI_CHANS_PER_STREAM + chan][bidx] = stream_in[k];
			// the frame just completed is what the next frame plays out
			if (pos_model == `TSI_NUM_SLOTS - 1)
			begin
				for (i = 0; i < `TSI_NUM_SLOTS; i++)
					prev_frame[i] = cur_frame[i];
				played_model = 1'b1;
			end
			pos_model = (pos_model + 1) % `TSI_NUM_SLOTS;
			bit_times++;
		end
		if (control.write)
			conn_model[control.addr] = control.data; // seen from the next bit time on
	endtask

	// new inputs for the next cycle with valid high on about three cycles in four
	task automatic drive_random();
		tsi_conn_pkg::conn_write_t req;
		req.write = ($random(seed) & 7) == 0; // roughly one write in eight cycles
		req.addr = tsi_frame_pkg::slot_t'($random(seed));
		req.data = tsi_conn_pkg::conn_word_t'($random(seed));
		input_valid <= ($random(seed) & 3) != 0;
		stream_in <= tsi_frame_pkg::stream_bits_t'($random(seed));
		control <= req;
	endtask

	task automatic check_streams(input tsi_frame_pkg::stream_bits_t expected);
		checks++;
		if (stream_out !== expected)
		begin
			$display("[FAIL] %0t ns: stream_out is %b, expected %b (bit time %0d)",
				$time, stream_out, expected, bit_times);
			$display("tests failed");
			$fatal(1, "stopping at the first stream mismatch");
		end
	endtask

	task automatic check_sync(input logic expected);
		checks++;
		if (sync !== expected)
		begin
			$display("[FAIL] %0t ns: sync is %b, expected %b (bit time %0d)",
				$time, sync, expected, bit_times);
			$display("tests failed");
			$fatal(1, "stopping at the first sync mismatch");
		end
	endtask

	// the bound property checker counts its failed assertions
	task automatic stop_on_assertion_failure();
		if (u_tsi_switch.u_tsi_switch_props.failures != 0)
		begin
			$display("%0d assertion failures in the property checker",
				u_tsi_switch.u_tsi_switch_props.failures);
			$display("tests failed");
			$fatal(1, "property checks did not hold");
		end
	endtask

	// a stuck run ends here once the cycle limit is reached
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("timeout: only %0d of %0d bit times done after %0d cycles",
				bit_times, RUN_BIT_TIMES, cycle_count);
			$display("tests failed");
			$fatal(1, "run did not finish in time");
		end
	end

	initial
	begin
		seed = 32'haefd4f58;
		bit_times = 0;
		cycle_count = 0;
		checks = 0;
		reset <= 1'b1;
		input_valid <= 1'b0;
		control <= '0;
		stream_in <= '0;
		model_reset();

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0; // the eighth edge is the last one that sees reset
		drive_random();
		@(negedge clk);
		check_streams(exp_stream); // outputs quiet right after reset
		check_sync(exp_sync);

		// outputs are compared at the falling edge half a cycle after they move
		while (bit_times < RUN_BIT_TIMES)
		begin
			@(posedge clk);
			apply_edge();
			drive_random();
			@(negedge clk);
			check_streams(exp_stream);
			check_sync(exp_sync);
			stop_on_assertion_failure();
		end

		$display("%0d checks over %0d bit times", checks, bit_times);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+src
src/tsi_frame_pkg.sv
src/tsi_conn_pkg.sv
src/tsi_frame_counter.sv
src/tsi_conn_memory.sv
src/tsi_speech_memory.sv
src/tsi_output_select.sv
src/tsi_switch.sv
testbench/tsi_switch_props.sv
testbench/tsi_switch_tb.sv
